// File: dmaBusPkg.sv
// widths of the fifo side of the dma controller, imported by the fifo counter and the top level.
package dmaBusPkg;

    // enough for a depth of up to 15 longwords.
    localparam int FIFO_COUNT_W = 4;

    // number of longwords held in the fifo.
    typedef logic [FIFO_COUNT_W-1:0] fifoCount_t;

endpackage

// File: cpuSmPkg.sv
// state encoding and product-term layout shared by the bus master decoders, imported where used.
package cpuSmPkg;

    // bus master states, IDLE at zero so reset lands there.
    typedef enum logic [4:0] {
        IDLE    = 5'd0,
        ARB     = 5'd1,                     // bus request out, waiting for grant.
        ADDR    = 5'd2,                     // address strobe cycle.
        DATA    = 5'd3,                     // data strobe, waiting for acknowledge.
        TERM    = 5'd4,                     // cycle finished, decide keep or release.
        RELEASE = 5'd5                      // bus handed back.
    } cpuState_t;

    localparam int SM_TERM_COUNT = 9;

    typedef logic [SM_TERM_COUNT-1:0] smTerms_t;

    // bit positions inside smTerms_t.
    typedef enum logic [3:0] {
        T_REQREAD   = 4'd0,                 // fifo has room, cpu to fifo.
        T_REQWRITE  = 4'd1,                 // fifo has data, fifo to cpu.
        T_GRANTED   = 4'd2,
        T_ACK32     = 4'd3,                 // full longword port.
        T_ACK16     = 4'd4,                 // word port only.
        T_ACKANY    = 4'd5,
        T_WORDDONE  = 4'd6,                 // whole fifo longword moved.
        T_KEEPBUS   = 4'd7,
        T_FLUSHDONE = 4'd8
    } smTermIdx_t;

endpackage

// File: cpuSmInputs.sv
// input decoder of the bus master, folds bus, dma and fifo inputs into the product-term vector.
`timescale 1ns/1ns

module cpuSmInputs (
    input  cpuSmPkg::cpuState_t state,
    input  logic                A1,
    input  logic                nBGRANT,
    input  logic                DMADIR,
    input  logic                DMAENA,
    input  logic                nDREQ,
    input  logic                nDSACK0,
    input  logic                nDSACK1,
    input  logic                nSTERM,
    input  logic                FIFOEMPTY,
    input  logic                FIFOFULL,
    input  logic                FLUSHFIFO,
    input  logic                LASTWORD,
    output cpuSmPkg::smTerms_t  terms
);

    import cpuSmPkg::*;

    logic dmaReq;                           // peripheral asking for service.
    logic reqRead;
    logic reqWrite;
    logic ack32;
    logic ack16;
    logic dirReq;                           // request matching the current direction.

    // active-low bus signals are turned around here and nowhere else.
    assign dmaReq   = DMAENA & ~nDREQ;
    assign reqRead  = dmaReq & ~DMADIR & ~FIFOFULL;
    assign reqWrite = dmaReq & DMADIR & ~FIFOEMPTY;
    assign dirReq   = DMADIR ? reqWrite : reqRead;

    // stERM counts as a full 32 bit termination.
    assign ack32 = ~nSTERM | (~nDSACK0 & ~nDSACK1);
    assign ack16 = ~nDSACK1 & nDSACK0 & nSTERM;

    always_comb begin
        terms = '0;
        terms[T_REQREAD]   = reqRead;
        terms[T_REQWRITE]  = reqWrite;
        terms[T_GRANTED]   = ~nBGRANT;
        terms[T_ACK32]     = ack32;
        terms[T_ACK16]     = ack16;
        terms[T_ACKANY]    = ack32 | ack16;
        terms[T_WORDDONE]  = ack32 | (ack16 & A1);  // upper half of a 16 bit pair.
        terms[T_KEEPBUS]   = (state == TERM) & dirReq & ~LASTWORD;
        terms[T_FLUSHDONE] = FLUSHFIFO & DMADIR & FIFOEMPTY;
    end

endmodule

// File: cpuSmOutputs.sv
// output decoder of the bus master, gives strobes, fifo pulses and the next state per state.
`timescale 1ns/1ns

module cpuSmOutputs (
    input  cpuSmPkg::cpuState_t state,
    input  cpuSmPkg::smTerms_t  terms,
    input  logic                A1,
    input  logic                DMADIR,
    output logic                BREQ,
    output logic                BGACK,
    output logic                PAS,
    output logic                PDS,
    output logic                SIZE1,
    output logic                F2CPUL,
    output logic                F2CPUH,
    output logic                PLLW,
    output logic                PLHW,
    output logic                BRIDGEOUT,
    output logic                BRIDGEIN,
    output logic                INCFIFO,
    output logic                DECFIFO,
    output logic                INCNI,
    output logic                INCNO,
    output logic                STOPFLUSH,
    output cpuSmPkg::cpuState_t nextState
);

    import cpuSmPkg::*;

    always_comb begin
        BREQ      = 1'b0;
        BGACK     = 1'b0;
        PAS       = 1'b0;
        PDS       = 1'b0;
        SIZE1     = 1'b0;
        F2CPUL    = 1'b0;
        F2CPUH    = 1'b0;
        PLLW      = 1'b0;
        PLHW      = 1'b0;
        BRIDGEOUT = 1'b0;
        BRIDGEIN  = 1'b0;
        INCFIFO   = 1'b0;
        DECFIFO   = 1'b0;
        INCNI     = 1'b0;
        INCNO     = 1'b0;
        STOPFLUSH = 1'b0;
        nextState = state;

        case (state)
            IDLE: begin
                STOPFLUSH = terms[T_FLUSHDONE];
                if (terms[T_REQREAD] | terms[T_REQWRITE]) begin
                    nextState = ARB;
                end
            end
            ARB: begin
                BREQ = 1'b1;                // dropped on the granted edge.
                if (terms[T_GRANTED]) begin
                    nextState = ADDR;
                end
            end
            ADDR: begin
                BGACK     = 1'b1;
                PAS       = 1'b1;
                SIZE1     = A1;
                nextState = DATA;
            end
            DATA: begin
                BGACK = 1'b1;
                PAS   = 1'b1;
                PDS   = 1'b1;
                SIZE1 = A1;
                if (DMADIR) begin
                    // fifo to cpu, high half only goes out on an even word.
                    BRIDGEOUT = 1'b1;
                    F2CPUL    = 1'b1;
                    F2CPUH    = ~A1;
                    INCNO     = terms[T_ACKANY];
                    DECFIFO   = terms[T_WORDDONE];
                end else begin
                    // cpu to fifo, latch the half the slave returned.
                    BRIDGEIN = 1'b1;
                    PLHW     = terms[T_ACK32] | (terms[T_ACK16] & ~A1);
                    PLLW     = terms[T_ACK32] | (terms[T_ACK16] & A1);
                    INCNI    = terms[T_ACKANY];
                    INCFIFO  = terms[T_WORDDONE];
                end
                if (terms[T_ACKANY]) begin
                    nextState = TERM;
                end
            end
            TERM: begin
                BGACK     = 1'b1;
                nextState = terms[T_KEEPBUS] ? ADDR : RELEASE;
            end
            RELEASE: begin
                nextState = IDLE;           // one dead cycle with bgack low.
            end
            default: begin
                nextState = IDLE;           // unused encodings recover.
            end
        endcase
    end

endmodule

// File: cpuSmInternals.sv
// bus master state machine, state register between the input and output decoders.
`timescale 1ns/1ns

module cpuSmInternals (
    input  logic CLK90,
    input  logic nRESET,
    input  logic A1,
    input  logic nBGRANT,
    input  logic DMADIR,
    input  logic DMAENA,
    input  logic nDREQ,
    input  logic nDSACK0,
    input  logic nDSACK1,
    input  logic nSTERM,
    input  logic FIFOEMPTY,
    input  logic FIFOFULL,
    input  logic FLUSHFIFO,
    input  logic LASTWORD,
    output logic BREQ,
    output logic BGACK,
    output logic PAS,
    output logic PDS,
    output logic SIZE1,
    output logic F2CPUL,
    output logic F2CPUH,
    output logic PLLW,
    output logic PLHW,
    output logic BRIDGEOUT,
    output logic BRIDGEIN,
    output logic INCFIFO,
    output logic DECFIFO,
    output logic INCNI,
    output logic INCNO,
    output logic STOPFLUSH
);

    import cpuSmPkg::*;

    cpuState_t state;
    cpuState_t nextState;
    smTerms_t  terms;

    cpuSmInputs uInputs (
        .state     (state     ),
        .A1        (A1        ),
        .nBGRANT   (nBGRANT   ),
        .DMADIR    (DMADIR    ),
        .DMAENA    (DMAENA    ),
        .nDREQ     (nDREQ     ),
        .nDSACK0   (nDSACK0   ),
        .nDSACK1   (nDSACK1   ),
        .nSTERM    (nSTERM    ),
        .FIFOEMPTY (FIFOEMPTY ),
        .FIFOFULL  (FIFOFULL  ),
        .FLUSHFIFO (FLUSHFIFO ),
        .LASTWORD  (LASTWORD  ),
        .terms     (terms     )
    );

    cpuSmOutputs uOutputs (
        .state     (state     ),
        .terms     (terms     ),
        .A1        (A1        ),
        .DMADIR    (DMADIR    ),
        .BREQ      (BREQ      ),
        .BGACK     (BGACK     ),
        .PAS       (PAS       ),
        .PDS       (PDS       ),
        .SIZE1     (SIZE1     ),
        .F2CPUL    (F2CPUL    ),
        .F2CPUH    (F2CPUH    ),
        .PLLW      (PLLW      ),
        .PLHW      (PLHW      ),
        .BRIDGEOUT (BRIDGEOUT ),
        .BRIDGEIN  (BRIDGEIN  ),
        .INCFIFO   (INCFIFO   ),
        .DECFIFO   (DECFIFO   ),
        .INCNI     (INCNI     ),
        .INCNO     (INCNO     ),
        .STOPFLUSH (STOPFLUSH ),
        .nextState (nextState )
    );

    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            state <= IDLE;
        end else begin
            state <= nextState;             // one transition per edge.
        end
    end

endmodule

// File: fifoControl.sv
// longword occupancy counter of the dma fifo, feeds empty and full back to the bus master.
`timescale 1ns/1ns

module fifoControl #(
    parameter int FIFO_DEPTH = 8            // longwords, 1 to 15.
) (
    input  logic                  CLK90,
    input  logic                  nRESET,
    input  logic                  INCFIFO,
    input  logic                  DECFIFO,
    output logic                  FIFOEMPTY,
    output logic                  FIFOFULL,
    output dmaBusPkg::fifoCount_t fifoLevel
);

    import dmaBusPkg::*;

    localparam fifoCount_t DEPTH_COUNT = fifoCount_t'(FIFO_DEPTH);
    localparam fifoCount_t ONE         = fifoCount_t'(1);

    fifoCount_t count;

    assign FIFOEMPTY = (count == '0);
    assign FIFOFULL  = (count == DEPTH_COUNT);
    assign fifoLevel = count;

    // pulses from DATA land while the machine sits in TERM.
    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            count <= '0;
        end else begin
            case ({INCFIFO, DECFIFO})
                2'b10: begin
                    if (!FIFOFULL) begin
                        count <= count + ONE;       // word written in from the bus.
                    end
                end
                2'b01: begin
                    if (!FIFOEMPTY) begin
                        count <= count - ONE;       // word sent out to the bus.
                    end
                end
                default: begin
                    count <= count;                 // both or neither cancel.
                end
            endcase
        end
    end

endmodule

// File: cpuSmTop.sv
// top of the scsi dma bus master, joins the state machine and the fifo occupancy counter.
`timescale 1ns/1ns

module cpuSmTop #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  CLK90,
    input  logic                  nRESET,
    input  logic                  A1,
    input  logic                  nBGRANT,
    input  logic                  DMADIR,
    input  logic                  DMAENA,
    input  logic                  nDREQ,
    input  logic                  nDSACK0,
    input  logic                  nDSACK1,
    input  logic                  nSTERM,
    input  logic                  FLUSHFIFO,
    input  logic                  LASTWORD,
    output logic                  BREQ,
    output logic                  BGACK,
    output logic                  PAS,
    output logic                  PDS,
    output logic                  SIZE1,
    output logic                  F2CPUL,
    output logic                  F2CPUH,
    output logic                  PLLW,
    output logic                  PLHW,
    output logic                  BRIDGEOUT,
    output logic                  BRIDGEIN,
    output logic                  INCFIFO,
    output logic                  DECFIFO,
    output logic                  INCNI,
    output logic                  INCNO,
    output logic                  STOPFLUSH,
    output dmaBusPkg::fifoCount_t fifoLevel
);

    logic fifoEmpty;                        // flags looped back into the machine.
    logic fifoFull;

    cpuSmInternals uSm (
        .CLK90     (CLK90     ),
        .nRESET    (nRESET    ),
        .A1        (A1        ),
        .nBGRANT   (nBGRANT   ),
        .DMADIR    (DMADIR    ),
        .DMAENA    (DMAENA    ),
        .nDREQ     (nDREQ     ),
        .nDSACK0   (nDSACK0   ),
        .nDSACK1   (nDSACK1   ),
        .nSTERM    (nSTERM    ),
        .FIFOEMPTY (fifoEmpty ),
        .FIFOFULL  (fifoFull  ),
        .FLUSHFIFO (FLUSHFIFO ),
        .LASTWORD  (LASTWORD  ),
        .BREQ      (BREQ      ),
        .BGACK     (BGACK     ),
        .PAS       (PAS       ),
        .PDS       (PDS       ),
        .SIZE1     (SIZE1     ),
        .F2CPUL    (F2CPUL    ),
        .F2CPUH    (F2CPUH    ),
        .PLLW      (PLLW      ),
        .PLHW      (PLHW      ),
        .BRIDGEOUT (BRIDGEOUT ),
        .BRIDGEIN  (BRIDGEIN  ),
        .INCFIFO   (INCFIFO   ),
        .DECFIFO   (DECFIFO   ),
        .INCNI     (INCNI     ),
        .INCNO     (INCNO     ),
        .STOPFLUSH (STOPFLUSH )
    );

    fifoControl #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uFifo (
        .CLK90     (CLK90     ),
        .nRESET    (nRESET    ),
        .INCFIFO   (INCFIFO   ),
        .DECFIFO   (DECFIFO   ),
        .FIFOEMPTY (fifoEmpty ),
        .FIFOFULL  (fifoFull  ),
        .fifoLevel (fifoLevel )
    );

endmodule

// File: cpuSm_properties.sv
// protocol assertions on the bus master strobes, bound into the state machine in simulation.
`timescale 1ns/1ns

module cpuSmProperties (
    input logic CLK90,
    input logic nRESET,
    input logic BREQ,
    input logic BGACK,
    input logic PAS,
    input logic PDS,
    input logic INCFIFO,
    input logic DECFIFO
);

    pdsNeedsPas: assert property (@(posedge CLK90) disable iff (!nRESET) PDS |-> PAS)
        else $error("data strobe without address strobe");

    fifoPulsesApart: assert property (@(posedge CLK90) disable iff (!nRESET)
                                      !(INCFIFO && DECFIFO))
        else $error("fifo increment and decrement together");

    // request and acknowledge never overlap.
    arbApart: assert property (@(posedge CLK90) disable iff (!nRESET) !(BREQ && BGACK))
        else $error("bus request while bus held");

    quietInReset: assert property (@(posedge CLK90) !nRESET |-> !(BREQ || BGACK || PAS || PDS))
        else $error("bus strobe active in reset");

endmodule

bind cpuSmInternals cpuSmProperties uProps (
    .CLK90 (CLK90), .nRESET (nRESET), .BREQ (BREQ), .BGACK (BGACK),
    .PAS (PAS), .PDS (PDS), .INCFIFO (INCFIFO), .DECFIFO (DECFIFO)
);

// File: tb_cpuSm.sv
// testbench for the bus master, a random bus slave checked each cycle against a cycle model.
`timescale 1ns/1ns

module tb_cpuSm;

    import dmaBusPkg::*;

    localparam int FIFO_DEPTH     = 4;
    localparam int BURSTS         = 80;
    localparam int BURST_LIMIT    = 200;    // cycles before a burst counts as hung.
    localparam int MAX_BUS_CYCLES = 12;     // LASTWORD forced after this many.

    typedef enum logic [2:0] {M_IDLE, M_ARB, M_ADDR, M_DATA, M_TERM, M_RELEASE} modelState_t;

    logic CLK90, nRESET;
    logic A1, nBGRANT, DMADIR, DMAENA, nDREQ, FLUSHFIFO, LASTWORD;
    logic nDSACK0, nDSACK1, nSTERM;
    logic BREQ, BGACK, PAS, PDS, SIZE1;
    logic F2CPUL, F2CPUH, PLLW, PLHW, BRIDGEOUT, BRIDGEIN;
    logic INCFIFO, DECFIFO, INCNI, INCNO, STOPFLUSH;
    fifoCount_t fifoLevel;

    modelState_t modelState, modelNext;
    int modelCount;                         // longwords the model thinks are held.
    logic eBreq, eBgack, ePas, ePds, eSize1;
    logic eF2cpul, eF2cpuh, ePllw, ePlhw, eBridgeOut, eBridgeIn;
    logic eIncFifo, eDecFifo, eIncNi, eIncNo, eStopFlush;
    int readWords, writeWords, flushHits;
    bit runDone;

    cpuSmTop #(.FIFO_DEPTH(FIFO_DEPTH)) uut (.*);

    initial begin
        CLK90 = 1'b0;
        forever #10 CLK90 = ~CLK90;
    end

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        runDone = 1'b1;
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            stopWithFailure($sformatf("FAILED at %0t ns: %s is %0h, expected %0h",
                                      $time, name, actual, expected));
        end
    endtask

    // expected outputs and next state from the model state and the driven inputs.
    function automatic void predictCycle();
        logic reqRead, reqWrite, ack32, ack16, wordDone, keepBus;
        reqRead  = DMAENA && !nDREQ && !DMADIR && modelCount != FIFO_DEPTH;
        reqWrite = DMAENA && !nDREQ && DMADIR && modelCount != 0;
        ack32    = !nSTERM || (!nDSACK0 && !nDSACK1);
        ack16    = !nDSACK1 && nDSACK0 && nSTERM;
        wordDone = ack32 || (ack16 && A1);
        keepBus  = (DMADIR ? reqWrite : reqRead) && !LASTWORD;
        {eBreq, eBgack, ePas, ePds, eSize1} = '0;
        {eF2cpul, eF2cpuh, ePllw, ePlhw, eBridgeOut, eBridgeIn} = '0;
        {eIncFifo, eDecFifo, eIncNi, eIncNo, eStopFlush} = '0;
        modelNext = modelState;
        case (modelState)
            M_IDLE: begin
                eStopFlush = FLUSHFIFO && DMADIR && modelCount == 0;
                modelNext  = (reqRead || reqWrite) ? M_ARB : M_IDLE;
            end
            M_ARB: begin
                eBreq     = 1'b1;
                modelNext = nBGRANT ? M_ARB : M_ADDR;
            end
            M_ADDR: begin
                {eBgack, ePas} = 2'b11;
                eSize1    = A1;
                modelNext = M_DATA;
            end
            M_DATA: begin
                {eBgack, ePas, ePds} = 3'b111;
                eSize1 = A1;
                if (DMADIR) begin
                    {eBridgeOut, eF2cpul} = 2'b11;
                    eF2cpuh  = !A1;             // high half only on an even word.
                    eIncNo   = ack32 || ack16;
                    eDecFifo = wordDone;
                end else begin
                    eBridgeIn = 1'b1;
                    ePlhw     = ack32 || (ack16 && !A1);
                    ePllw     = ack32 || (ack16 && A1);
                    eIncNi    = ack32 || ack16;
                    eIncFifo  = wordDone;
                end
                modelNext = (ack32 || ack16) ? M_TERM : M_DATA;
            end
            M_TERM: begin
                eBgack    = 1'b1;
                modelNext = keepBus ? M_ADDR : M_RELEASE;
            end
            default: modelNext = M_IDLE;
        endcase
    endfunction

    // check just before the edge, then advance the model and land 2 ns after the edge.
    task automatic stepCycle();
        #17;
        predictCycle();
        compareValue("BREQ", 32'(BREQ), 32'(eBreq));
        compareValue("BGACK", 32'(BGACK), 32'(eBgack));
        compareValue("PAS", 32'(PAS), 32'(ePas));
        compareValue("PDS", 32'(PDS), 32'(ePds));
        compareValue("SIZE1", 32'(SIZE1), 32'(eSize1));
        compareValue("F2CPUL", 32'(F2CPUL), 32'(eF2cpul));
        compareValue("F2CPUH", 32'(F2CPUH), 32'(eF2cpuh));
        compareValue("PLLW", 32'(PLLW), 32'(ePllw));
        compareValue("PLHW", 32'(PLHW), 32'(ePlhw));
        compareValue("BRIDGEOUT", 32'(BRIDGEOUT), 32'(eBridgeOut));
        compareValue("BRIDGEIN", 32'(BRIDGEIN), 32'(eBridgeIn));
        compareValue("INCFIFO", 32'(INCFIFO), 32'(eIncFifo));
        compareValue("DECFIFO", 32'(DECFIFO), 32'(eDecFifo));
        compareValue("INCNI", 32'(INCNI), 32'(eIncNi));
        compareValue("INCNO", 32'(INCNO), 32'(eIncNo));
        compareValue("STOPFLUSH", 32'(STOPFLUSH), 32'(eStopFlush));
        compareValue("fifoLevel", 32'(fifoLevel), 32'(modelCount));
        readWords  += int'(eIncFifo);
        writeWords += int'(eDecFifo);
        flushHits  += int'(eStopFlush);
        @(posedge CLK90);
        if (!nRESET) begin
            modelState = M_IDLE;
            modelCount = 0;
        end else begin
            if (eIncFifo && modelCount < FIFO_DEPTH) modelCount++;
            if (eDecFifo && modelCount > 0) modelCount--;
            modelState = modelNext;
        end
        #2;
    endtask

    // one request from IDLE back to IDLE, the testbench acting as arbiter and slave.
    task automatic runBurst(input logic dir);
        int cycles;
        int grantDelay;
        int waitLeft;
        int ackKind;
        int busCycles;
        cycles     = 0;
        busCycles  = 0;
        waitLeft   = 0;
        ackKind    = 0;
        grantDelay = $urandom_range(3, 0);
        {DMADIR, DMAENA, nDREQ, LASTWORD} = {dir, 1'b1, 1'b0, 1'b0};
        FLUSHFIFO = 1'($urandom_range(1, 0));
        A1        = 1'($urandom_range(1, 0));
        do begin
            nBGRANT = 1'b1;
            case (modelState)
                M_ARB: begin
                    if (grantDelay == 0) nBGRANT = 1'b0;
                    else grantDelay--;
                end
                M_ADDR: begin
                    A1        = 1'($urandom_range(1, 0));   // new bus cycle.
                    waitLeft  = $urandom_range(3, 0);
                    ackKind   = $urandom_range(2, 0);       // 32 bit, 16 bit or STERM.
                    busCycles++;
                    if ($urandom_range(7, 0) == 0) nDREQ = 1'b1;
                    if ($urandom_range(5, 0) == 0 || busCycles >= MAX_BUS_CYCLES) LASTWORD = 1'b1;
                    {nDSACK0, nDSACK1, nSTERM} = 3'b111;
                end
                M_DATA: begin
                    if (waitLeft > 0) begin
                        waitLeft--;                         // slave holds the cycle off.
                    end else begin
                        nDSACK0 = !(ackKind == 0);
                        nDSACK1 = !(ackKind <= 1);
                        nSTERM  = !(ackKind == 2);
                    end
                end
                default: {nDSACK0, nDSACK1, nSTERM} = 3'b111;
            endcase
            stepCycle();
            cycles++;
            if (cycles >= BURST_LIMIT) stopWithFailure("timeout: burst never returned to IDLE");
        end while (modelState != M_IDLE);
        {DMAENA, nDREQ, LASTWORD, nBGRANT} = 4'b0101;
    endtask

    // quiet bus, flush inputs shaken to exercise STOPFLUSH.
    task automatic idleGap(input int count);
        repeat (count) begin
            DMADIR    = 1'($urandom_range(1, 0));
            FLUSHFIFO = 1'($urandom_range(1, 0));
            A1        = 1'($urandom_range(1, 0));
            stepCycle();
        end
    endtask

    initial begin
        {nRESET, A1, nBGRANT, DMADIR, DMAENA, nDREQ} = 6'b001001;
        {nDSACK0, nDSACK1, nSTERM, FLUSHFIFO, LASTWORD} = 5'b11100;
        modelState = M_IDLE;
        modelCount = 0;
        readWords  = 0;
        writeWords = 0;
        flushHits  = 0;
        runDone = 1'b0;
        void'($urandom(66));
        @(posedge CLK90);
        #2;
        repeat (5) stepCycle();                     // outputs checked low in reset.
        nRESET = 1'b1;
        for (int i = 0; i < BURSTS; i++) begin
            runBurst(1'($urandom_range(1, 0)));
            idleGap(3);
        end
        if (readWords == 0 || writeWords == 0 || flushHits == 0) begin
            stopWithFailure("no read word, write word or flush completion was ever seen");
        end else begin
            runDone = 1'b1;
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    // run stopped early by a failed assertion.
    final begin
        if (!runDone) begin
            $display("TESTBENCH FAILED");
        end
    end

endmodule

// File: dmaCpuSm.f
dmaBusPkg.sv
cpuSmPkg.sv
cpuSmInputs.sv
cpuSmOutputs.sv
cpuSmInternals.sv
fifoControl.sv
cpuSmTop.sv
cpuSm_properties.sv
tb_cpuSm.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpuSm
RTL_TOP   ?= cpuSmTop
FILELIST  ?= dmaCpuSm.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= dmaBusPkg.sv cpuSmPkg.sv cpuSmInputs.sv cpuSmOutputs.sv \
             cpuSmInternals.sv fifoControl.sv cpuSmTop.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
